// File: sim.f
+incdir+common
+incdir+testbench
common/cpu_pkg.sv
design/run_control.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu_core.sv
testbench/tb_cpu_top.sv

// File: testbench/tb_cpu_tests.svh
`ifndef TB_CPU_TESTS_SVH
`define TB_CPU_TESTS_SVH

// ----------------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------------
task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
        errors++;
        $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_daddr(input string name, input daddr_t got, input daddr_t exp);
    if (got !== exp)
    begin
        errors++;
        $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_iaddr(input string name, input iaddr_t got, input iaddr_t exp);
    if (got !== exp)
    begin
        errors++;
        $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
        errors++;
        $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
endtask

// ----------------------------------------------------------------------------
// program building
// ----------------------------------------------------------------------------
function automatic word_t enc_rrr(opcode_t op, reg_idx_t r1, reg_idx_t r2, reg_idx_t r3);
    return {op, r1, 1'b0, r2, 1'b0, r3};
endfunction

function automatic word_t enc_ri8(opcode_t op, reg_idx_t r1, logic [7:0] imm);
    return {op, r1, imm};
endfunction

function automatic word_t enc_rri4(opcode_t op, reg_idx_t r1, reg_idx_t r2, logic [3:0] imm);
    return {op, r1, 1'b0, r2, imm};
endfunction

// depends on all address bits
function automatic word_t ram_fill(input int a);
    return {a[7:0] ^ 8'h3c, a[7:0]};
endfunction

task automatic next_cycle();
    @(posedge clk);
    #5;
endtask

task automatic emit(input word_t w);
    rom[emit_pc] = w;
    emit_pc++;
endtask

// three slots between a register write and its reader
task automatic emit_gap();
    repeat (3) emit({NOP, 11'b0});
endtask

task automatic load_reg(input reg_idx_t r, input word_t v);
    emit(enc_ri8(SET, r, v[7:0]));
    emit_gap();
    emit(enc_ri8(LDIH, r, v[15:8]));
    emit_gap();
endtask

task automatic store_expect(input reg_idx_t r, input logic [3:0] addr, input word_t v);
    emit(enc_rri4(STORE, r, 3'd0, addr));
    exp_addr.push_back(daddr_t'(addr));
    exp_data.push_back(v);
endtask

task automatic reset_dut();
    next_cycle();
    rst_n  = 1'b0;
    enable = 1'b0;
    start  = 1'b0;
    for (int i = 0; i < (1 << `CPU_IADDR_W); i++)
        rom[i] = {NOP, 11'b0};
    for (int i = 0; i < (1 << `CPU_DADDR_W); i++)
        ram[i] = ram_fill(i);
    log_addr.delete();
    log_data.delete();
    exp_addr.delete();
    exp_data.delete();
    emit_pc         = 0;
    errors_at_start = errors;
    repeat (3) @(posedge clk);
    #5;
    rst_n = 1'b1;
endtask

task automatic run_program();
    next_cycle();
    enable = 1'b1;
    start  = 1'b1;
    next_cycle();
    start = 1'b0;
    while (!running)
        @(negedge clk);
    while (running)
        @(negedge clk);
endtask

task automatic check_stores();
    if (log_addr.size() != exp_addr.size())
    begin
        errors++;
        $display("wrong number of stores: got %0d, expected %0d",
                 log_addr.size(), exp_addr.size());
    end
    for (int i = 0; i < log_addr.size() && i < exp_addr.size(); i++)
    begin
        check_daddr("d_addr", log_addr[i], exp_addr[i]);
        check_word("d_dataout", log_data[i], exp_data[i]);
    end
endtask

task automatic finish_test(input string name);
    tests_run++;
    $display("test %s done, %0d errors", name, errors - errors_at_start);
endtask

// ----------------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------------
task automatic test_reset_idle();
    reset_dut();
    rom[0] = {HALT, 11'b0};
    start  = 1'b1;
    repeat (3) next_cycle();
    check_bit("running", running, 1'b0);
    check_bit("d_we", d_we, 1'b0);
    check_iaddr("i_addr", i_addr, '0);
    enable = 1'b1;
    next_cycle();
    check_bit("running", running, 1'b1);
    start = 1'b0;
    while (running)
        @(negedge clk);
    finish_test("reset_idle");
endtask

task automatic test_arith_logic();
    word_t      a;
    word_t      b;
    logic [7:0] k;
    reset_dut();
    a = word_t'($urandom);
    b = word_t'($urandom);
    k = 8'($urandom);
    load_reg(1, a);
    load_reg(2, b);
    emit(enc_rrr(ADD, 3, 1, 2));
    emit_gap();
    store_expect(3, 0, a + b);
    emit(enc_ri8(ADDI, 3, k));
    emit_gap();
    store_expect(3, 1, a + b + k);
    emit(enc_rrr(SUB, 4, 1, 2));
    emit_gap();
    store_expect(4, 2, a - b);
    emit(enc_ri8(SUBI, 4, k));
    emit_gap();
    store_expect(4, 3, a - b - k);
    emit(enc_rrr(AND, 5, 1, 2));
    emit_gap();
    store_expect(5, 4, a & b);
    emit(enc_rrr(OR, 5, 1, 2));
    emit_gap();
    store_expect(5, 5, a | b);
    emit(enc_rrr(XOR, 5, 1, 2));
    emit_gap();
    store_expect(5, 6, a ^ b);
    emit({HALT, 11'b0});
    run_program();
    check_stores();
    finish_test("arith_logic");
endtask

task automatic test_carry_shift();
    opcode_t sh_ops [4] = '{SLL, SRL, SLA, SRA};
    word_t   x;
    word_t   y;
    word_t   sh;
    int      s;
    logic    c;
    reset_dut();
    // both top bits set, so ADD always carries
    x = word_t'($urandom) | 16'h8000;
    y = word_t'($urandom) | 16'h8000;
    load_reg(1, x);
    load_reg(2, y);
    emit(enc_rrr(ADD, 3, 1, 2));
    emit(enc_rrr(ADDC, 4, 1, 2));
    emit_gap();
    store_expect(4, 0, x + y + 16'd1);
    emit(enc_rrr(AND, 3, 1, 2));
    emit(enc_rrr(ADDC, 4, 1, 2));
    emit_gap();
    store_expect(4, 1, x + y);
    emit(enc_rrr(SUB, 3, 1, 2));
    emit(enc_rrr(SUBC, 4, 1, 2));
    emit_gap();
    c = (x < y);
    store_expect(4, 2, x - y - word_t'(c));
    emit(enc_rrr(SUB, 3, 2, 1));
    emit(enc_rrr(SUBC, 4, 2, 1));
    emit_gap();
    c = (y < x);
    store_expect(4, 3, y - x - word_t'(c));
    for (int i = 0; i < 4; i++)
    begin
        s = $urandom % 16;
        case (sh_ops[i])
            SRL:     sh = x >> s;
            // vacated top bits take copies of the sign bit
            SRA:     sh = (x >> s) | (x[15] ? ~(16'hffff >> s) : 16'h0000);
            default: sh = x << s;
        endcase
        emit(enc_rri4(sh_ops[i], 5, 1, 4'(s)));
        emit_gap();
        store_expect(5, 4'(4 + i), sh);
    end
    emit({HALT, 11'b0});
    run_program();
    check_stores();
    finish_test("carry_shift");
endtask

task automatic test_load_store();
    logic [7:0] base;
    logic [3:0] off_ld;
    logic [3:0] off_st;
    daddr_t     ld_addr;
    daddr_t     st_addr;
    word_t      v;
    reset_dut();
    base    = 8'($urandom);
    off_ld  = 4'($urandom);
    off_st  = off_ld + 4'd1;
    ld_addr = daddr_t'(base + off_ld);
    st_addr = daddr_t'(base + off_st);
    v       = ram_fill(int'(ld_addr)) + 16'h0011;
    emit(enc_ri8(SET, 2, base));
    emit_gap();
    emit(enc_rri4(LOAD, 3, 2, off_ld));
    emit_gap();
    emit(enc_ri8(ADDI, 3, 8'h11));
    emit_gap();
    emit(enc_rri4(STORE, 3, 2, off_st));
    exp_addr.push_back(st_addr);
    exp_data.push_back(v);
    emit({HALT, 11'b0});
    run_program();
    check_stores();
    check_word("ram", ram[st_addr], v);
    finish_test("load_store");
endtask

function automatic logic cond_taken(opcode_t op, logic zf, logic nf, logic cf);
    case (op)
        BZ:      return zf;
        BNZ:     return !zf;
        BN:      return nf;
        BNN:     return !nf;
        BC:      return cf;
        default: return !cf;
    endcase
endfunction

// branch, three delay-slot stores, fall-through store, target store
task automatic branch_case(input opcode_t op, input reg_idx_t r, input int rval,
                           input logic taken);
    int target;
    target = emit_pc + 5;
    emit(enc_ri8(op, r, 8'(target - rval)));
    store_expect(1, 1, 16'd5);
    store_expect(1, 2, 16'd5);
    store_expect(1, 3, 16'd5);
    if (taken)
        emit(enc_rri4(STORE, 1, 0, 4));
    else
        store_expect(1, 4, 16'd5);
    store_expect(1, 5, 16'd5);
endtask

task automatic test_branches();
    opcode_t br_ops [6] = '{BZ, BNZ, BN, BNN, BC, BNC};
    word_t   bval;
    word_t   diff;
    reset_dut();
    emit(enc_ri8(SET, 1, 8'd5));
    emit(enc_ri8(SET, 2, 8'd5));
    emit(enc_ri8(SET, 3, 8'd9));
    emit(enc_ri8(SET, 4, 8'd16));
    emit_gap();
    for (int i = 0; i < 6; i++)
    begin
        for (int p = 0; p < 2; p++)
        begin
            bval = (p == 1) ? 16'd9 : 16'd5;
            diff = 16'd5 - bval;
            emit(enc_rrr(CMP, 0, 1, (p == 1) ? 3'd3 : 3'd2));
            branch_case(br_ops[i], 0, 0,
                        cond_taken(br_ops[i], diff == '0, diff[15], 16'd5 < bval));
        end
    end
    branch_case(JUMP, 0, 0, 1'b1);
    branch_case(JMPR, 4, 16, 1'b1);
    emit({HALT, 11'b0});
    run_program();
    check_stores();
    finish_test("branches");
endtask

task automatic test_halt_enable();
    int halt_pc;
    int n;
    int first_errors;
    reset_dut();
    emit(enc_ri8(SET, 1, 8'h33));
    emit_gap();
    store_expect(1, 2, 16'h0033);
    halt_pc = emit_pc;
    emit({HALT, 11'b0});
    run_program();
    check_stores();
    // pc steps on until the HALT leaves write-back
    check_iaddr("i_addr", i_addr, iaddr_t'(halt_pc + 5));
    repeat (5) next_cycle();
    check_iaddr("i_addr", i_addr, iaddr_t'(halt_pc + 5));
    // no restart without a reset
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    repeat (3) next_cycle();
    check_bit("running", running, 1'b0);

    // the enable run counts toward the same test
    first_errors = errors_at_start;
    reset_dut();
    errors_at_start = first_errors;
    for (int i = 0; i < (1 << `CPU_IADDR_W); i++)
        rom[i] = enc_rri4(STORE, 0, 0, 4'd7);
    next_cycle();
    enable = 1'b1;
    start  = 1'b1;
    next_cycle();
    start = 1'b0;
    repeat (10) next_cycle();
    enable = 1'b0;
    repeat (2) next_cycle();
    check_bit("running", running, 1'b0);
    n = log_addr.size();
    if (n == 0)
    begin
        errors++;
        $display("no stores seen before enable was dropped");
    end
    repeat (10) next_cycle();
    if (log_addr.size() != n)
    begin
        errors++;
        $display("stores continued after enable was dropped");
    end
    finish_test("halt_enable");
endtask

`endif

// File: testbench/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu_top
    import cpu_pkg::*;
();

    // longest program is about 110 slots, six runs stay well under 500 cycles
    localparam int TIMEOUT_CYCLES = 3000;

    logic   clk;
    logic   rst_n;
    logic   enable;
    logic   start;
    word_t  i_datain;
    word_t  d_datain;
    iaddr_t i_addr;
    daddr_t d_addr;
    logic   d_we;
    word_t  d_dataout;
    logic   running;

    // instruction ROM and data RAM, both read combinationally
    word_t  rom [1 << `CPU_IADDR_W];
    word_t  ram [1 << `CPU_DADDR_W];

    // stores seen on the bus and stores the model predicts
    daddr_t log_addr [$];
    word_t  log_data [$];
    daddr_t exp_addr [$];
    word_t  exp_data [$];

    int errors;
    int errors_at_start;
    int tests_run;
    int cycles;
    int emit_pc;

    assign i_datain = rom[i_addr];
    assign d_datain = ram[d_addr];

    cpu_core dut0 (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (d_we)
            ram[d_addr] <= d_dataout;
    end

    // a frozen pipeline holds d_we, so only running cycles count as stores
    always @(negedge clk)
    begin
        if (running && d_we)
        begin
            log_addr.push_back(d_addr);
            log_data.push_back(d_dataout);
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    `include "tb_cpu_tests.svh"

    initial
    begin
        void'($urandom(52));
        errors    = 0;
        tests_run = 0;
        cycles    = 0;
        rst_n     = 1'b0;
        enable    = 1'b0;
        start     = 1'b0;

        test_reset_idle();
        test_arith_logic();
        test_carry_shift();
        test_load_store();
        test_branches();
        test_halt_enable();

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   enable,
    input  logic   start,
    input  word_t  i_datain,
    input  word_t  d_datain,
    output iaddr_t i_addr,
    output daddr_t d_addr,
    output logic   d_we,
    output word_t  d_dataout,
    output logic   running
);

    // fetch -> decode
    word_t    id_ir;

    // register file read side
    reg_idx_t rd_idx_a;
    reg_idx_t rd_idx_b;
    reg_idx_t rd_idx_c;
    word_t    rd_data_a;
    word_t    rd_data_b;
    word_t    rd_data_c;

    // decode -> execute
    word_t    ex_ir;
    word_t    opnd_a;
    word_t    opnd_b;
    word_t    store_data;

    // execute -> memory
    word_t    mem_ir;
    word_t    result;
    logic     zf;
    logic     nf;
    logic     cf;

    // memory stage back to fetch, control and register file
    logic     branch_taken;
    iaddr_t   branch_target;
    opcode_t  wb_op;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;

    run_control   u_run_control   (.*);
    fetch_stage   u_fetch_stage   (.*);
    register_file u_register_file (.*);
    decode_stage  u_decode_stage  (.*);
    execute_stage u_execute_stage (.*);
    memory_stage  u_memory_stage  (.*);

endmodule

`default_nettype wire

// File: design/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module memory_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     running,
    input  word_t    mem_ir,
    input  word_t    result,
    input  logic     zf,
    input  logic     nf,
    input  logic     cf,
    input  word_t    d_datain,
    output daddr_t   d_addr,
    output logic     branch_taken,
    output iaddr_t   branch_target,
    output opcode_t  wb_op,
    output logic     wr_en,
    output reg_idx_t wr_idx,
    output word_t    wr_data
);

    opcode_t mem_op;
    daddr_t  daddr_q;
    logic    mem_access;

    assign mem_op     = op_of(mem_ir);
    assign mem_access = (mem_op == LOAD) || (mem_op == STORE);

    // address follows the result on an access, else the last store address
    assign d_addr = mem_access ? daddr_t'(result) : daddr_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            daddr_q <= '0;
        else if (running && (mem_op == STORE))
            daddr_q <= daddr_t'(result);
    end

    // ------------------------------------------------------------------------
    // branch decision
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (mem_op)
            JUMP, JMPR: branch_taken = 1'b1;
            BZ:         branch_taken = zf;
            BNZ:        branch_taken = !zf;
            BN:         branch_taken = nf;
            BNN:        branch_taken = !nf;
            BC:         branch_taken = cf;
            BNC:        branch_taken = !cf;
            default:    branch_taken = 1'b0;
        endcase
    end

    assign branch_target = iaddr_t'(result);

    // ------------------------------------------------------------------------
    // write-back register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_op <= NOP;
            wr_en <= 1'b0;
        end
        else if (running)
        begin
            // a HALT stays here until reset
            wb_op <= (wb_op == HALT) ? HALT : mem_op;
            wr_en <= mem_op inside {LOAD, LDIH, ADD, ADDI, ADDC, SUB, SUBI, SUBC,
                                    AND, OR, XOR, SLL, SRL, SLA, SRA, SET};
        end
    end

    always_ff @(posedge clk)
    begin
        if (running)
        begin
            wr_idx  <= mem_ir[`CPU_R1_LSB +: `CPU_REG_IDX_W];
            wr_data <= (mem_op == LOAD) ? d_datain : result;
        end
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  running,
    input  word_t ex_ir,
    input  word_t opnd_a,
    input  word_t opnd_b,
    input  word_t store_data,
    output word_t mem_ir,
    output word_t result,
    output logic  d_we,
    output word_t d_dataout,
    output logic  zf,
    output logic  nf,
    output logic  cf
);

    opcode_t                 ex_op;
    logic [`CPU_SHAMT_W-1:0] shamt;
    word_t                   alu_out;
    logic                    alu_cf;
    logic                    flag_op;

    assign ex_op = op_of(ex_ir);
    assign shamt = opnd_b[`CPU_SHAMT_W-1:0];

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    always_comb
    begin
        alu_cf  = cf;
        alu_out = opnd_a + opnd_b;
        case (ex_op)
            AND:
            begin
                alu_cf  = 1'b0;
                alu_out = opnd_a & opnd_b;
            end
            OR:
            begin
                alu_cf  = 1'b0;
                alu_out = opnd_a | opnd_b;
            end
            XOR:
            begin
                alu_cf  = 1'b0;
                alu_out = opnd_a ^ opnd_b;
            end
            SET:
            begin
                alu_cf  = 1'b0;
                alu_out = opnd_b;
            end
            // shifts keep the carry
            SLL, SLA:
                alu_out = opnd_a << shamt;
            SRL:
                alu_out = opnd_a >> shamt;
            SRA:
                alu_out = word_t'($signed(opnd_a) >>> shamt);
            ADD, ADDI:
                {alu_cf, alu_out} = {1'b0, opnd_a} + {1'b0, opnd_b};
            ADDC:
                {alu_cf, alu_out} = {1'b0, opnd_a} + {1'b0, opnd_b} + cf;
            // bit 16 of the difference is the borrow
            SUB, SUBI, CMP:
                {alu_cf, alu_out} = {1'b0, opnd_a} - {1'b0, opnd_b};
            SUBC:
                {alu_cf, alu_out} = {1'b0, opnd_a} - {1'b0, opnd_b} - cf;
            default:
                ;
        endcase
    end

    assign flag_op = ex_op inside {LDIH, ADD, ADDI, ADDC, SUB, SUBI, SUBC, CMP,
                                   AND, OR, XOR, SLL, SRL, SLA, SRA, SET};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem_ir <= NOP_IR;
            d_we   <= 1'b0;
            zf     <= 1'b0;
            nf     <= 1'b0;
            cf     <= 1'b0;
        end
        else if (running)
        begin
            mem_ir <= ex_ir;
            d_we   <= (ex_op == STORE);
            if (flag_op)
            begin
                zf <= (alu_out == '0);
                nf <= alu_out[`CPU_WORD_W-1];
                cf <= alu_cf;
            end
        end
    end

    // result doubles as data address and branch target
    always_ff @(posedge clk)
    begin
        if (running)
        begin
            result <= alu_out;
            if (ex_op == STORE)
                d_dataout <= store_data;
        end
    end

    a_ex_op_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        running |-> !$isunknown(ex_ir[`CPU_OP_LSB +: `CPU_OP_W])
    );

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module decode_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     running,
    input  word_t    id_ir,
    output reg_idx_t rd_idx_a,
    output reg_idx_t rd_idx_b,
    output reg_idx_t rd_idx_c,
    input  word_t    rd_data_a,
    input  word_t    rd_data_b,
    input  word_t    rd_data_c,
    output word_t    ex_ir,
    output word_t    opnd_a,
    output word_t    opnd_b,
    output word_t    store_data
);

    opcode_t                 id_op;
    logic [`CPU_SHAMT_W-1:0] imm4;
    logic [`CPU_R1_LSB-1:0]  imm8;

    assign id_op = op_of(id_ir);
    assign imm4  = id_ir[`CPU_SHAMT_W-1:0];
    assign imm8  = id_ir[`CPU_R1_LSB-1:0];

    // port a reads r1, b reads r2, c reads r3
    assign rd_idx_a = id_ir[`CPU_R1_LSB +: `CPU_REG_IDX_W];
    assign rd_idx_b = id_ir[`CPU_R2_LSB +: `CPU_REG_IDX_W];
    assign rd_idx_c = id_ir[`CPU_REG_IDX_W-1:0];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ex_ir <= NOP_IR;
        else if (running)
            ex_ir <= id_ir;
    end

    // ------------------------------------------------------------------------
    // operand registers, left alone by opcodes that do not use them
    // ------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (running)
        begin
            if (id_op == STORE)
                store_data <= rd_data_a;

            case (id_op)
                JUMP:
                    opnd_a <= '0;
                LDIH, ADDI, SUBI, SET, JMPR, BZ, BNZ, BN, BNN, BC, BNC:
                    opnd_a <= rd_data_a;
                LOAD, STORE, ADD, ADDC, SUB, SUBC, CMP, AND, OR, XOR,
                SLL, SRL, SLA, SRA:
                    opnd_a <= rd_data_b;
                default:
                    ;
            endcase

            case (id_op)
                // address offset or shift amount
                LOAD, STORE, SLL, SRL, SLA, SRA:
                    opnd_b <= word_t'(imm4);
                ADDI, SUBI, SET, JUMP, JMPR, BZ, BNZ, BN, BNN, BC, BNC:
                    opnd_b <= word_t'(imm8);
                LDIH:
                    opnd_b <= {imm8, {(`CPU_WORD_W - `CPU_R1_LSB){1'b0}}};
                ADD, ADDC, SUB, SUBC, CMP, AND, OR, XOR:
                    opnd_b <= rd_data_c;
                default:
                    ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module register_file
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     running,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    input  reg_idx_t rd_idx_c,
    output word_t    rd_data_a,
    output word_t    rd_data_b,
    output word_t    rd_data_c,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);

    word_t regs [`CPU_NREGS];

    // no bypass, a write is visible to decode one cycle later
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];
    assign rd_data_c = regs[rd_idx_c];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_NREGS; i++)
                regs[i] <= '0;
        end
        else if (running && wr_en)
            regs[wr_idx] <= wr_data;
    end

    a_wr_idx_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (running && wr_en) |-> !$isunknown(wr_idx)
    );

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   running,
    input  logic   branch_taken,
    input  iaddr_t branch_target,
    input  word_t  i_datain,
    output iaddr_t i_addr,
    output word_t  id_ir
);

    iaddr_t pc;

    // instruction memory is addressed straight from the pc
    assign i_addr = pc;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc    <= '0;
            id_ir <= NOP_IR;
        end
        else if (running)
        begin
            id_ir <= i_datain;
            // taken branch resolves in memory, three slots behind
            if (branch_taken)
                pc <= branch_target;
            else
                pc <= pc + iaddr_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: design/run_control.sv
`timescale 1ns/1ps
`default_nettype none

module run_control
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    enable,
    input  logic    start,
    input  opcode_t wb_op,
    output logic    running
);

    typedef enum logic {IDLE, RUN} state_t;

    state_t state;
    state_t next_state;

    // a HALT stays in write-back while frozen, so it also blocks a restart
    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
                if (enable && start && (wb_op != HALT))
                    next_state = RUN;
            RUN:
                if (!enable || (wb_op == HALT))
                    next_state = IDLE;
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= next_state;
    end

    assign running = (state == RUN);

    a_no_start_without_enable: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(running) |-> $past(enable)
    );

endmodule

`default_nettype wire

// File: common/cpu_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0]    word_t;
    typedef logic [`CPU_IADDR_W-1:0]   iaddr_t;
    typedef logic [`CPU_DADDR_W-1:0]   daddr_t;
    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

    // 00100..00111 are unused
    typedef enum logic [`CPU_OP_W-1:0] {
        NOP   = 5'b00000,
        HALT  = 5'b00001,
        LOAD  = 5'b00010,
        STORE = 5'b00011,
        LDIH  = 5'b01000,
        ADD   = 5'b01001,
        ADDI  = 5'b01010,
        ADDC  = 5'b01011,
        SUB   = 5'b01100,
        SUBI  = 5'b01101,
        SUBC  = 5'b01110,
        CMP   = 5'b01111,
        AND   = 5'b10000,
        OR    = 5'b10001,
        XOR   = 5'b10010,
        SLL   = 5'b10011,
        SRL   = 5'b10100,
        SLA   = 5'b10101,
        SRA   = 5'b10110,
        SET   = 5'b10111,
        JUMP  = 5'b11000,
        JMPR  = 5'b11001,
        BZ    = 5'b11010,
        BNZ   = 5'b11011,
        BN    = 5'b11100,
        BNN   = 5'b11101,
        BC    = 5'b11110,
        BNC   = 5'b11111
    } opcode_t;

    // instruction word that pipeline registers reset to
    localparam word_t NOP_IR = {NOP, {(`CPU_WORD_W - `CPU_OP_W){1'b0}}};

    function automatic opcode_t op_of(input word_t ir);
        return opcode_t'(ir[`CPU_OP_LSB +: `CPU_OP_W]);
    endfunction

endpackage

`default_nettype wire

// File: common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath widths
`define CPU_WORD_W      16
`define CPU_IADDR_W     8
`define CPU_DADDR_W     8

// register file
`define CPU_NREGS       8
`define CPU_REG_IDX_W   3

// instruction word layout
`define CPU_OP_W        5
`define CPU_SHAMT_W     4
`define CPU_OP_LSB      11
`define CPU_R1_LSB      8
`define CPU_R2_LSB      4

`endif
